// ==== vlog.f ====
source/if_pkg.sv
source/if_pc_select.sv
source/if_fetch_unit.sv
source/if_id_register.sv
source/if_pc_check.sv
source/if_stage.sv
verif/if_stage_assertions.sv
verif/if_checker.sv
verif/tb_if_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the fetch stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_if_stage -f vlog.f -o sim_if_stage
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_if_stage +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0

// ==== verif/tb_if_stage.sv ====
// testbench for the instruction fetch stage
// clock, reset, instruction memory model, test sequence, timeout and verdict

`timescale 1ns/10ps

module tb_if_stage import if_pkg::*; ();

  localparam xlen_t       HaltAddr   = 32'h1A110800;
  localparam xlen_t       DbgExcAddr = 32'h1A110808;
  localparam xlen_t       DataKey    = 32'hA5C3_0F96;
  // words in this window answer with a bus error
  localparam xlen_t       ErrLo      = 32'h0000_3000;
  localparam xlen_t       ErrHi      = 32'h0000_301C;
  // six tests at roughly 600 cycles each at worst, plus margin
  localparam int unsigned MaxCycles  = 4000;

  logic        clk;
  logic        rst_n;
  logic        req;
  logic        instr_req;
  xlen_t       instr_addr;
  logic        instr_gnt;
  logic        instr_rvalid;
  xlen_t       instr_rdata;
  logic        instr_bus_err;
  logic        pc_set;
  pc_sel_e     pc_mux;
  exc_pc_sel_e exc_pc_mux;
  exc_cause_t  exc_cause;
  xlen_t       boot_addr;
  xlen_t       branch_target;
  xlen_t       csr_mepc;
  xlen_t       csr_depc;
  xlen_t       csr_mtvec;
  logic        id_in_ready;
  logic        instr_valid_clear;
  logic        instr_valid_id;
  logic        instr_new_id;
  id_instr_t   id_instr;
  xlen_t       pc_if;
  logic        csr_mtvec_init;
  logic        pc_mismatch_alert;
  logic        if_busy;
  int          test_num;
  logic        test_done;
  logic        summary;
  int          error_count;
  int unsigned cycle_count;

  if_stage #(
    .DmHaltAddr      (HaltAddr),
    .DmExceptionAddr (DbgExcAddr)
  ) i_dut (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .req_i               (req),
    .instr_req_o         (instr_req),
    .instr_addr_o        (instr_addr),
    .instr_gnt_i         (instr_gnt),
    .instr_rvalid_i      (instr_rvalid),
    .instr_rdata_i       (instr_rdata),
    .instr_bus_err_i     (instr_bus_err),
    .pc_set_i            (pc_set),
    .pc_mux_i            (pc_mux),
    .exc_pc_mux_i        (exc_pc_mux),
    .exc_cause_i         (exc_cause),
    .boot_addr_i         (boot_addr),
    .branch_target_i     (branch_target),
    .csr_mepc_i          (csr_mepc),
    .csr_depc_i          (csr_depc),
    .csr_mtvec_i         (csr_mtvec),
    .id_in_ready_i       (id_in_ready),
    .instr_valid_clear_i (instr_valid_clear),
    .instr_valid_id_o    (instr_valid_id),
    .instr_new_id_o      (instr_new_id),
    .id_instr_o          (id_instr),
    .pc_if_o             (pc_if),
    .csr_mtvec_init_o    (csr_mtvec_init),
    .pc_mismatch_alert_o (pc_mismatch_alert),
    .if_busy_o           (if_busy)
  );

  if_checker #(
    .DmHaltAddr      (HaltAddr),
    .DmExceptionAddr (DbgExcAddr),
    .DataKey         (DataKey),
    .ErrLo           (ErrLo),
    .ErrHi           (ErrHi)
  ) i_checker (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .pc_set_i            (pc_set),
    .pc_mux_i            (pc_mux),
    .exc_pc_mux_i        (exc_pc_mux),
    .exc_cause_i         (exc_cause),
    .boot_addr_i         (boot_addr),
    .branch_target_i     (branch_target),
    .csr_mepc_i          (csr_mepc),
    .csr_depc_i          (csr_depc),
    .csr_mtvec_i         (csr_mtvec),
    .id_in_ready_i       (id_in_ready),
    .instr_valid_clear_i (instr_valid_clear),
    .instr_valid_id_i    (instr_valid_id),
    .instr_new_id_i      (instr_new_id),
    .id_instr_i          (id_instr),
    .csr_mtvec_init_i    (csr_mtvec_init),
    .pc_mismatch_alert_i (pc_mismatch_alert),
    .instr_req_i         (instr_req),
    .instr_gnt_i         (instr_gnt),
    .instr_rvalid_i      (instr_rvalid),
    .pc_if_i             (pc_if),
    .if_busy_i           (if_busy),
    .test_num_i          (test_num),
    .test_done_i         (test_done),
    .summary_i           (summary),
    .error_count_o       (error_count)
  );

  bind if_stage if_stage_assertions i_assertions (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_req_i         (instr_req_o),
    .instr_addr_i        (instr_addr_o),
    .instr_gnt_i         (instr_gnt_i),
    .fetch_valid_i       (fetch.valid),
    .instr_valid_id_i    (instr_valid_id_o),
    .instr_new_id_i      (instr_new_id_o),
    .csr_mtvec_init_i    (csr_mtvec_init_o),
    .pc_mismatch_alert_i (pc_mismatch_alert_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////

  // one transaction at a time, random grant and response delays
  initial begin : mem_model
    xlen_t addr;
    instr_gnt     = 1'b0;
    instr_rvalid  = 1'b0;
    instr_rdata   = '0;
    instr_bus_err = 1'b0;
    addr          = '0;
    @(negedge clk);
    forever begin
      instr_gnt     = 1'b0;
      instr_rvalid  = 1'b0;
      instr_bus_err = 1'b0;
      if (instr_req) begin
        repeat ($urandom_range(3, 0)) @(negedge clk);
        instr_gnt = 1'b1;
        addr      = instr_addr;
        @(negedge clk);
        instr_gnt = 1'b0;
        // response no earlier than the cycle after grant
        repeat ($urandom_range(3, 0)) @(negedge clk);
        instr_rvalid  = 1'b1;
        instr_rdata   = addr ^ DataKey;
        instr_bus_err = (addr >= ErrLo) && (addr <= ErrHi);
      end
      @(negedge clk);
    end
  end

  // run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < MaxCycles) begin
      @(posedge clk);
      cycle_count = cycle_count + 1;
    end
    $display("timeout: tests did not finish within %0d cycles", MaxCycles);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // stimulus tasks, all entered and left on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic set_pc(input pc_sel_e sel, input exc_pc_sel_e exc_sel);
    pc_mux     = sel;
    exc_pc_mux = exc_sel;
    pc_set     = 1'b1;
    @(negedge clk);
    pc_set = 1'b0;
  endtask

  // wait for n instructions in ID, optionally with random decode stalls
  task automatic run_instrs(input int n, input bit stall);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(posedge clk);
      if (instr_new_id) begin
        seen = seen + 1;
      end
      @(negedge clk);
      id_in_ready = stall ? ($urandom_range(3, 0) != 0) : 1'b1;
    end
    id_in_ready = 1'b1;
  endtask

  task automatic hold_stall(input int cycles);
    id_in_ready = 1'b0;
    repeat (cycles) @(negedge clk);
    id_in_ready = 1'b1;
  endtask

  task automatic end_test(input int num);
    test_num  = num;
    test_done = 1'b1;
    @(negedge clk);
    test_done = 1'b0;
  endtask

  initial begin : stimulus
    void'($urandom(20));
    rst_n             = 1'b0;
    req               = 1'b0;
    pc_set            = 1'b0;
    pc_mux            = PC_BOOT;
    exc_pc_mux        = EXC_PC_EXC;
    exc_cause         = '0;
    boot_addr         = 32'h0000_105A;
    branch_target     = '0;
    csr_mepc          = '0;
    csr_depc          = '0;
    csr_mtvec         = '0;
    id_in_ready       = 1'b1;
    instr_valid_clear = 1'b1;
    test_num          = 0;
    test_done         = 1'b0;
    summary           = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // one quiet cycle out of reset before the core asks for fetches
    @(negedge clk);
    req   = 1'b1;

    // boot, low bits of the boot address are junk on purpose
    set_pc(PC_BOOT, EXC_PC_EXC);
    run_instrs(12, 1'b0);
    end_test(1);

    // every redirect source once
    for (int i = 0; i < 8; i++) begin
      branch_target = 32'h0002_0000 | ($urandom & 32'h0000_FFFC);
      csr_mepc      = 32'h0004_0000 | ($urandom & 32'h0000_FFFC);
      csr_depc      = 32'h0006_0000 | ($urandom & 32'h0000_FFFC);
      csr_mtvec     = 32'h0008_0000 | ($urandom & 32'h0000_FF01);
      exc_cause     = {1'b0, 5'($urandom_range(30, 0))};
      case (i)
        0: set_pc(PC_JUMP, EXC_PC_EXC);
        1: set_pc(PC_ERET, EXC_PC_EXC);
        2: set_pc(PC_DRET, EXC_PC_EXC);
        3: set_pc(PC_EXC, EXC_PC_EXC);
        4: set_pc(PC_EXC, EXC_PC_IRQ);
        5: begin
          // internal interrupt
          exc_cause.irq_int = 1'b1;
          set_pc(PC_EXC, EXC_PC_IRQ);
        end
        6: set_pc(PC_EXC, EXC_PC_DBD);
        default: set_pc(PC_EXC, EXC_PC_DBG_EXC);
      endcase
      run_instrs(5, 1'b0);
    end
    end_test(2);

    branch_target = 32'h0000_8000;
    set_pc(PC_JUMP, EXC_PC_EXC);
    run_instrs(30, 1'b1);
    end_test(3);

    // decode keeps valid without clearing, then stalls
    branch_target     = 32'h0000_9000;
    instr_valid_clear = 1'b0;
    set_pc(PC_JUMP, EXC_PC_EXC);
    run_instrs(3, 1'b0);
    hold_stall(12);
    instr_valid_clear = 1'b1;
    run_instrs(2, 1'b0);
    end_test(4);

    // walk across the error window
    branch_target = ErrLo - 32'd8;
    set_pc(PC_JUMP, EXC_PC_EXC);
    run_instrs(14, 1'b0);
    end_test(5);

    csr_mepc = 32'h0000_A004;
    set_pc(PC_ERET, EXC_PC_EXC);
    run_instrs(10, 1'b1);
    end_test(6);

    summary = 1'b1;
    @(negedge clk);
    summary = 1'b0;
    if ((error_count == 0) && (i_dut.i_assertions.fail_count == 0)) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verif/if_checker.sv ====
// fetch stage checker
// predicts the pc sequence after each pc set and compares what reaches decode

`timescale 1ns/10ps

module if_checker import if_pkg::*; #(
  parameter xlen_t DmHaltAddr      = 32'h1A110800,
  parameter xlen_t DmExceptionAddr = 32'h1A110808,
  parameter xlen_t DataKey         = 32'h0,
  parameter xlen_t ErrLo           = 32'h0,
  parameter xlen_t ErrHi           = 32'h0
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  exc_cause_t  exc_cause_i,
  input  xlen_t       boot_addr_i,
  input  xlen_t       branch_target_i,
  input  xlen_t       csr_mepc_i,
  input  xlen_t       csr_depc_i,
  input  xlen_t       csr_mtvec_i,
  input  logic        id_in_ready_i,
  input  logic        instr_valid_clear_i,
  input  logic        instr_valid_id_i,
  input  logic        instr_new_id_i,
  input  id_instr_t   id_instr_i,
  input  logic        csr_mtvec_init_i,
  input  logic        pc_mismatch_alert_i,
  input  logic        instr_req_i,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  xlen_t       pc_if_i,
  input  logic        if_busy_i,
  input  int          test_num_i,
  input  logic        test_done_i,
  input  logic        summary_i,
  output int          error_count_o
);

  xlen_t exp_pc;
  logic  exp_active;
  logic  valid_q;
  logic  clear_q;
  logic  ready_q;
  logic  set_q;
  xlen_t pc_if_q;
  logic  bus_pending;
  int    test_instrs;
  int    test_errors;
  int    total_instrs;
  int    total_errors;
  int    tests_run;

  // first pc after a set, straight from the selection rules
  function automatic xlen_t ref_next_pc(input pc_sel_e sel, input exc_pc_sel_e exc_sel,
                                        input exc_cause_t cause, input xlen_t boot,
                                        input xlen_t target, input xlen_t mepc,
                                        input xlen_t depc, input xlen_t mtvec);
    xlen_t base;
    xlen_t slot;
    base = mtvec & 32'hFFFF_FF00;
    slot = cause.irq_int ? 32'(NmiCause) : 32'(cause.lower_cause);
    case (sel)
      PC_BOOT: ref_next_pc = (boot & 32'hFFFF_FF00) + 32'(BootOffset);
      PC_JUMP: ref_next_pc = target;
      PC_ERET: ref_next_pc = mepc;
      PC_DRET: ref_next_pc = depc;
      default: begin
        case (exc_sel)
          EXC_PC_IRQ:     ref_next_pc = base + slot * 32'd4;
          EXC_PC_DBD:     ref_next_pc = DmHaltAddr;
          EXC_PC_DBG_EXC: ref_next_pc = DmExceptionAddr;
          default:        ref_next_pc = base;
        endcase
      end
    endcase
  endfunction

  function automatic logic in_err_window(input xlen_t addr);
    in_err_window = (addr >= ErrLo) && (addr <= ErrHi);
  endfunction

  function automatic string test_name(input int num);
    case (num)
      1:       test_name = "boot";
      2:       test_name = "redirect sources";
      3:       test_name = "back-pressure";
      4:       test_name = "valid hold";
      5:       test_name = "bus error";
      default: test_name = "mixed";
    endcase
  endfunction

  task automatic value_error(input string name, input xlen_t got, input xlen_t exp);
    $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
    test_errors = test_errors + 1;
  endtask

  task automatic other_error(input string msg);
    $display("%0t: %s", $time, msg);
    test_errors = test_errors + 1;
  endtask

  // samples pre-edge values, inputs settle on the falling edge
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      exp_pc       = '0;
      exp_active   = 1'b0;
      valid_q      = 1'b0;
      clear_q      = 1'b1;
      ready_q      = 1'b0;
      set_q        = 1'b0;
      pc_if_q      = '0;
      bus_pending  = 1'b0;
      test_instrs  = 0;
      test_errors  = 0;
      total_instrs = 0;
      total_errors = 0;
      tests_run    = 0;
    end else begin
      if (instr_new_id_i) begin
        if (!exp_active) begin
          other_error("instruction reached decode before any pc set");
        end else begin
          if (id_instr_i.pc !== exp_pc) begin
            value_error("id_instr_o.pc", id_instr_i.pc, exp_pc);
          end
          if (id_instr_i.rdata !== (exp_pc ^ DataKey)) begin
            value_error("id_instr_o.rdata", id_instr_i.rdata, exp_pc ^ DataKey);
          end
          if (id_instr_i.fetch_err !== in_err_window(exp_pc)) begin
            value_error("id_instr_o.fetch_err", {31'b0, id_instr_i.fetch_err},
                        {31'b0, in_err_window(exp_pc)});
          end
          // fetch pc seen in the cycle the word was handed over
          if (pc_if_q !== exp_pc) begin
            value_error("pc_if_o", pc_if_q, exp_pc);
          end
          exp_pc = exp_pc + 32'd4;
        end
        // a write needs decode ready and no squash in the cycle before
        if (!ready_q || set_q) begin
          other_error("instr_new_id_o pulsed without an accepted fetch");
        end
        test_instrs = test_instrs + 1;
      end
      if (valid_q && !clear_q && !instr_valid_id_i) begin
        value_error("instr_valid_id_o", 32'd0, 32'd1);
      end
      if (csr_mtvec_init_i !== (pc_set_i && (pc_mux_i == PC_BOOT))) begin
        value_error("csr_mtvec_init_o", {31'b0, csr_mtvec_init_i},
                    {31'b0, pc_set_i && (pc_mux_i == PC_BOOT)});
      end
      if (pc_mismatch_alert_i !== 1'b0) begin
        value_error("pc_mismatch_alert_o", {31'b0, pc_mismatch_alert_i}, 32'd0);
      end
      // busy from the request until its response comes back
      if (if_busy_i !== (instr_req_i || bus_pending)) begin
        value_error("if_busy_o", {31'b0, if_busy_i}, {31'b0, instr_req_i || bus_pending});
      end
      // new stream starts after anything already in decode
      if (pc_set_i) begin
        exp_pc     = ref_next_pc(pc_mux_i, exc_pc_mux_i, exc_cause_i, boot_addr_i,
                                 branch_target_i, csr_mepc_i, csr_depc_i, csr_mtvec_i);
        exp_active = 1'b1;
      end
      valid_q = instr_valid_id_i;
      clear_q = instr_valid_clear_i;
      ready_q = id_in_ready_i;
      set_q   = pc_set_i;
      pc_if_q = pc_if_i;
      // granted and still waiting for rvalid
      if (instr_req_i && instr_gnt_i) begin
        bus_pending = 1'b1;
      end else if (instr_rvalid_i) begin
        bus_pending = 1'b0;
      end
      if (test_done_i) begin
        $display("test %0d (%s) done: %0d instructions, %0d errors",
                 test_num_i, test_name(test_num_i), test_instrs, test_errors);
        total_instrs = total_instrs + test_instrs;
        total_errors = total_errors + test_errors;
        tests_run    = tests_run + 1;
        test_instrs  = 0;
        test_errors  = 0;
      end
      if (summary_i) begin
        $display("summary: %0d tests, %0d instructions checked, %0d errors",
                 tests_run, total_instrs, total_errors);
      end
    end
  end

  assign error_count_o = total_errors + test_errors;

endmodule

// ==== verif/if_stage_assertions.sv ====
// fetch stage assertions
// bus protocol on the instruction port and idle outputs out of reset

`timescale 1ns/10ps

module if_stage_assertions import if_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  instr_req_i,
  input xlen_t instr_addr_i,
  input logic  instr_gnt_i,
  input logic  fetch_valid_i,
  input logic  instr_valid_id_i,
  input logic  instr_new_id_i,
  input logic  csr_mtvec_init_i,
  input logic  pc_mismatch_alert_i
);

  int unsigned fail_count = 0;

  // request and its address stay put until grant
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (instr_req_i && !instr_gnt_i) |=> (instr_req_i && $stable(instr_addr_i)))
    else begin
      fail_count = fail_count + 1;
      $error("instruction request dropped or address changed before grant");
    end

  addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_i |-> (instr_addr_i[1:0] == 2'b00))
    else begin
      fail_count = fail_count + 1;
      $error("instruction address not word aligned");
    end

  // first edge out of reset sees the reset values
  idle_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!instr_req_i && !fetch_valid_i && !instr_valid_id_i &&
                       !instr_new_id_i && !csr_mtvec_init_i && !pc_mismatch_alert_i))
    else begin
      fail_count = fail_count + 1;
      $error("outputs not idle after reset");
    end

  new_has_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_i |-> instr_valid_id_i)
    else begin
      fail_count = fail_count + 1;
      $error("instr_new_id_o high without instr_valid_id_o");
    end

endmodule

// ==== source/if_stage.sv ====
// instruction fetch stage top level
// pc select, fetch unit, IF-ID register and pc check

`timescale 1ns/10ps

module if_stage import if_pkg::*; #(
  parameter xlen_t DmHaltAddr      = 32'h1A110800,
  parameter xlen_t DmExceptionAddr = 32'h1A110808
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  // instruction bus
  output logic        instr_req_o,
  output xlen_t       instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  xlen_t       instr_rdata_i,
  input  logic        instr_bus_err_i,
  // control from the core
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  exc_cause_t  exc_cause_i,
  input  xlen_t       boot_addr_i,
  input  xlen_t       branch_target_i,
  input  xlen_t       csr_mepc_i,
  input  xlen_t       csr_depc_i,
  input  xlen_t       csr_mtvec_i,
  input  logic        id_in_ready_i,
  input  logic        instr_valid_clear_i,
  // towards decode
  output logic        instr_valid_id_o,
  output logic        instr_new_id_o,
  output id_instr_t   id_instr_o,
  output xlen_t       pc_if_o,
  output logic        csr_mtvec_init_o,
  output logic        pc_mismatch_alert_o,
  output logic        if_busy_o
);

  xlen_t      fetch_addr_n;
  fetch_out_t fetch;
  logic       fetch_ready;
  logic       instr_new_d;

  if_pc_select #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) i_pc_select (
    .pc_mux_i         (pc_mux_i),
    .pc_set_i         (pc_set_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .exc_cause_i      (exc_cause_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .fetch_addr_n_o   (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // every pc set redirects the fetch unit
  if_fetch_unit i_fetch_unit (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .branch_i        (pc_set_i),
    .branch_addr_i   (fetch_addr_n),
    .ready_i         (fetch_ready),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_bus_err_i (instr_bus_err_i),
    .fetch_o         (fetch),
    .busy_o          (if_busy_o)
  );

  if_id_register i_id_register (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_i             (fetch),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready),
    .instr_new_d_o       (instr_new_d),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .id_instr_o          (id_instr_o)
  );

  if_pc_check i_pc_check (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_new_d_i       (instr_new_d),
    .branch_i            (pc_set_i),
    .fetch_i             (fetch),
    .pc_id_i             (id_instr_o.pc),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

  // address of the instruction waiting in the fetch buffer
  assign pc_if_o = fetch.addr;

endmodule

// ==== source/if_pc_check.sv ====
// sequential pc consistency check
// flags any fetch that does not follow the decode pc by one word

`timescale 1ns/10ps

module if_pc_check import if_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       instr_new_d_i,
  input  logic       branch_i,
  input  fetch_out_t fetch_i,
  input  xlen_t      pc_id_i,
  output logic       pc_mismatch_alert_o
);

  logic  seq_d, seq_q;
  logic  alert_d, alert_q;
  xlen_t pc_id_incr;

  // no check right after reset, a redirect or a faulting fetch
  assign seq_d = (seq_q | instr_new_d_i) & ~branch_i & ~(fetch_i.valid & fetch_i.err);

  assign pc_id_incr = pc_id_i + InstrBytes;
  // only a live fetch carries a meaningful address
  assign alert_d    = seq_q & fetch_i.valid & (fetch_i.addr != pc_id_incr);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q   <= 1'b0;
      alert_q <= 1'b0;
    end else begin
      seq_q   <= seq_d;
      alert_q <= alert_d;
    end
  end

  assign pc_mismatch_alert_o = alert_q;

endmodule

// ==== source/if_id_register.sv ====
// IF-ID pipeline register
// holds the instruction handed to decode, with its valid and new flags

`timescale 1ns/10ps

module if_id_register import if_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  fetch_out_t fetch_i,
  input  logic       id_in_ready_i,
  input  logic       pc_set_i,
  input  logic       instr_valid_clear_i,
  output logic       fetch_ready_o,
  output logic       instr_new_d_o,
  output logic       instr_valid_id_o,
  output logic       instr_new_id_o,
  output id_instr_t  id_instr_o
);

  logic      instr_valid_id_d, instr_valid_id_q;
  logic      instr_new_id_q;
  logic      id_we;
  id_instr_t id_instr_q;

  // decode pulls straight from the fetch buffer
  assign fetch_ready_o = id_in_ready_i;

  // write strobe, a fetch squashed by a pc set is not taken
  assign id_we = fetch_i.valid & id_in_ready_i & ~pc_set_i;

  // valid holds until decode clears it
  assign instr_valid_id_d = id_we | (instr_valid_id_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_q <= 1'b0;
      instr_new_id_q   <= 1'b0;
    end else begin
      instr_valid_id_q <= instr_valid_id_d;
      instr_new_id_q   <= id_we;
    end
  end

  // payload, frozen while decode stalls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_instr_q <= '0;
    end else if (id_we) begin
      id_instr_q.rdata     <= fetch_i.rdata;
      id_instr_q.pc        <= fetch_i.addr;
      id_instr_q.fetch_err <= fetch_i.err;
    end
  end

  assign instr_new_d_o    = id_we;
  assign instr_valid_id_o = instr_valid_id_q;
  // one cycle pulse per instruction entering decode
  assign instr_new_id_o   = instr_new_id_q;
  assign id_instr_o       = id_instr_q;

endmodule

// ==== source/if_fetch_unit.sv ====
// single outstanding fetch unit
// issues word requests on the instruction bus, drops responses that predate
// the last branch and keeps one fetched instruction for the IF-ID register

`timescale 1ns/10ps

module if_fetch_unit import if_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  logic       branch_i,
  input  xlen_t      branch_addr_i,
  input  logic       ready_i,
  // instruction bus
  output logic       instr_req_o,
  output xlen_t      instr_addr_o,
  input  logic       instr_gnt_i,
  input  logic       instr_rvalid_i,
  input  xlen_t      instr_rdata_i,
  input  logic       instr_bus_err_i,
  // towards IF-ID
  output fetch_out_t fetch_o,
  output logic       busy_o
);

  fetch_state_e state_q, state_d;
  xlen_t        fetch_addr_q, fetch_addr_d;
  xlen_t        req_addr_q, req_addr_d;
  xlen_t        branch_addr_w;
  xlen_t        next_req_addr;
  logic         discard_q, discard_d;
  logic         rsp_done;
  logic         rsp_drop;
  logic         buf_we;
  logic         buf_drain;
  fetch_out_t   buf_q, buf_d;

  // targets are forced onto a word boundary
  assign branch_addr_w = {branch_addr_i[31:2], 2'b00};
  assign next_req_addr = branch_i ? branch_addr_w : fetch_addr_q;

  // response of the outstanding request
  assign rsp_done  = (state_q == FETCH_WAIT_RVALID) & instr_rvalid_i;
  // stale if a branch came after it was issued, or comes right now
  assign rsp_drop  = discard_q | branch_i;
  assign buf_we    = rsp_done & ~rsp_drop;
  assign buf_drain = buf_q.valid & ready_i;

  ////////////////////////////////////////////////////////////
  // bus FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    req_addr_d = req_addr_q;
    unique case (state_q)
      FETCH_IDLE: begin
        // buffer is free, or frees up this cycle, or is flushed by the branch
        if (req_i & (branch_i | ~buf_q.valid | buf_drain)) begin
          state_d    = FETCH_WAIT_GNT;
          req_addr_d = next_req_addr;
        end
      end
      FETCH_WAIT_GNT: begin
        // request and address stay put until grant
        if (instr_gnt_i) begin
          state_d = FETCH_WAIT_RVALID;
        end
      end
      FETCH_WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          // a dropped response leaves the buffer empty, so go again at once
          if (req_i & rsp_drop) begin
            state_d    = FETCH_WAIT_GNT;
            req_addr_d = next_req_addr;
          end else begin
            state_d = FETCH_IDLE;
          end
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  // mark the request in flight as stale on a branch
  always_comb begin
    discard_d = discard_q;
    if (rsp_done) begin
      discard_d = 1'b0;
    end
    if (branch_i & ((state_q == FETCH_WAIT_GNT) |
                    ((state_q == FETCH_WAIT_RVALID) & ~instr_rvalid_i))) begin
      discard_d = 1'b1;
    end
  end

  // next word to fetch
  always_comb begin
    fetch_addr_d = fetch_addr_q;
    if (branch_i) begin
      fetch_addr_d = branch_addr_w;
    end else if (buf_we) begin
      fetch_addr_d = req_addr_q + InstrBytes;
    end
  end

  ////////////////////////////////////////////////////////////
  // response buffer
  ////////////////////////////////////////////////////////////

  always_comb begin
    buf_d = buf_q;
    if (buf_drain) begin
      buf_d.valid = 1'b0;
    end
    if (buf_we) begin
      buf_d.valid = 1'b1;
      buf_d.rdata = instr_rdata_i;
      buf_d.addr  = req_addr_q;
      buf_d.err   = instr_bus_err_i;
    end
    // flush on redirect
    if (branch_i) begin
      buf_d.valid = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= FETCH_IDLE;
      req_addr_q   <= '0;
      fetch_addr_q <= '0;
      discard_q    <= 1'b0;
      buf_q        <= '0;
    end else begin
      state_q      <= state_d;
      req_addr_q   <= req_addr_d;
      fetch_addr_q <= fetch_addr_d;
      discard_q    <= discard_d;
      buf_q        <= buf_d;
    end
  end

  assign instr_req_o  = (state_q == FETCH_WAIT_GNT);
  assign instr_addr_o = req_addr_q;
  assign fetch_o      = buf_q;
  assign busy_o       = (state_q != FETCH_IDLE);

endmodule

// ==== source/if_pc_select.sv ====
// next pc selection
// builds the exception vector and picks the next fetch address on a pc set

`timescale 1ns/10ps

module if_pc_select import if_pkg::*; #(
  parameter xlen_t DmHaltAddr      = 32'h1A110800,
  parameter xlen_t DmExceptionAddr = 32'h1A110808
) (
  input  pc_sel_e     pc_mux_i,
  input  logic        pc_set_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  exc_cause_t  exc_cause_i,
  input  xlen_t       boot_addr_i,
  input  xlen_t       branch_target_i,
  input  xlen_t       csr_mepc_i,
  input  xlen_t       csr_depc_i,
  input  xlen_t       csr_mtvec_i,
  output xlen_t       fetch_addr_n_o,
  output logic        csr_mtvec_init_o
);

  logic [4:0] irq_vec;
  xlen_t      exc_pc;
  xlen_t      boot_pc;

  // internal interrupts all land on the nmi entry
  assign irq_vec = exc_cause_i.irq_int ? NmiCause : exc_cause_i.lower_cause;

  // exception / interrupt / debug entry
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = {csr_mtvec_i[31:VecAlignBits], {VecAlignBits{1'b0}}};
      // vectored mode, cause times four above the base
      EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[31:VecAlignBits], {(VecAlignBits-7){1'b0}},
                                irq_vec, 2'b00};
      EXC_PC_DBD:     exc_pc = DmHaltAddr;
      EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:        exc_pc = {csr_mtvec_i[31:VecAlignBits], {VecAlignBits{1'b0}}};
    endcase
  end

  assign boot_pc = {boot_addr_i[31:VecAlignBits], BootOffset};

  // next fetch address
  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_n_o = boot_pc;
      PC_JUMP: fetch_addr_n_o = branch_target_i;
      PC_EXC:  fetch_addr_n_o = exc_pc;
      // return from trap / debug
      PC_ERET: fetch_addr_n_o = csr_mepc_i;
      PC_DRET: fetch_addr_n_o = csr_depc_i;
      default: fetch_addr_n_o = boot_pc;
    endcase
  end

  // csr file loads mtvec from the boot address
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

// ==== source/if_pkg.sv ====
// instruction fetch stage package
// shared types, encodings and constants for the fetch blocks

package if_pkg;

  // address or instruction word
  typedef logic [31:0] xlen_t;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  // exception target selection
  typedef enum logic [1:0] {
    EXC_PC_EXC,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBG_EXC
  } exc_pc_sel_e;

  // fetch unit bus FSM
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT_GNT,
    FETCH_WAIT_RVALID
  } fetch_state_e;

  ////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       irq_int;
    logic [4:0] lower_cause;
  } exc_cause_t;

  // fetched word handed from the fetch unit to IF-ID
  typedef struct packed {
    logic  valid;
    xlen_t rdata;
    xlen_t addr;
    logic  err;
  } fetch_out_t;

  // contents of the IF-ID register
  typedef struct packed {
    xlen_t rdata;
    xlen_t pc;
    logic  fetch_err;
  } id_instr_t;

  // boot entry sits this far above the aligned boot base
  localparam logic [7:0]  BootOffset   = 8'h80;
  // all internal interrupts share the NMI slot
  localparam logic [4:0]  NmiCause     = 5'd31;
  // low bits dropped from mtvec and boot address
  localparam int unsigned VecAlignBits = 8;
  // every instruction is one aligned word
  localparam xlen_t       InstrBytes   = 32'd4;

endpackage
